//--- run_sim.sh
#!/usr/bin/env bash
# Build the drawing engine testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing -f verilog.f --top-module tb_vdp_cmd -o tb_vdp_cmd; then
  echo "Verilator build failed"
  exit 1
fi

if ! ./obj_dir/tb_vdp_cmd > "$LOG" 2>&1; then
  echo "Simulation exited with an error status"
fi

cat "$LOG"

# The log decides the result
if grep -q "^NO ERRORS$" "$LOG"; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi

//--- tb_vdp_cmd.sv
`timescale 1ns/1ps
`default_nettype none

module tb_vdp_cmd import vdp_cmd_pkg::*; ();

  localparam int VRAM_BYTES = 131072;
  localparam int N_RAND     = 48;
  // Largest rectangle is 17 by 8 dots
  // About 20 cycles per dot plus register traffic
  localparam int CMD_CYCLES = 17 * 8 * 20 + 200;
  localparam int TIMEOUT_NS = (2 * N_RAND + 4) * CMD_CYCLES * 10;

  logic clk;
  logic reset;
  logic mode_graphic_4;
  logic mode_graphic_7;
  logic reg_wr_req;
  logic [3:0] reg_num;
  pixel_t reg_data;
  logic vram_rd_ack;
  logic vram_wr_ack;
  pixel_t vram_rd_data;
  logic reg_wr_ack;
  logic vram_rd_req;
  logic vram_wr_req;
  vram_addr_t vram_addr;
  pixel_t vram_wr_data;
  pixel_t clr;
  logic ce;
  logic [3:0] current_command;

  // VRAM as seen by the DUT and the reference copy
  logic [7:0] mem [0:VRAM_BYTES-1];
  logic [7:0] shadow [0:VRAM_BYTES-1];
  int wr_count;
  logic [31:0] stim_lfsr;
  logic [31:0] vram_lfsr;
  // Register values as last written
  logic [9:0] cur_dx;
  logic [9:0] cur_dy;
  logic [9:0] cur_nx;
  logic [9:0] cur_ny;
  logic cur_dix;
  logic cur_diy;
  logic [7:0] cur_clr;

  vdp_cmd_top dut_i (.*);

  always #5 clk = ~clk;

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bits(input int n, inout logic [31:0] state, output logic [31:0] v);
    v = '0;
    for (int k = 0; k < n; k++) begin
      state = lfsr_next(state);
      v = {v[30:0], state[0]};
    end
  endtask

  function automatic logic [7:0] fill_byte(input logic [16:0] a);
    return a[7:0] ^ a[15:8] ^ {7'h0, a[16]};
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
      $display("ERRORS FOUND");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  // 128 bytes per line in graphic 4 and 256 in graphic 7
  function automatic logic [16:0] vram_index(input logic g4, input logic [9:0] x,
                                             input logic [9:0] y);
    if (g4) return 17'(int'(y) * 128 + int'(x) / 2);
    return 17'(int'(y) * 256 + int'(x));
  endfunction

  // Even X is the high nibble
  function automatic logic [7:0] pixel_at(input logic g4, input logic [9:0] x,
                                          input logic [9:0] y);
    logic [7:0] b;
    b = shadow[vram_index(g4, x, y)];
    if (!g4) return b;
    return x[0] ? {4'h0, b[3:0]} : {4'h0, b[7:4]};
  endfunction

  function automatic logic [7:0] logic_op(input logic [3:0] lo, input logic [7:0] src,
                                          input logic [7:0] dst);
    // Transparent with colour 0 keeps the destination
    if (lo[3] && src == 8'h00) return dst;
    case (lo[2:0])
      3'd0: return src;
      3'd1: return src & dst;
      3'd2: return src | dst;
      3'd3: return src ^ dst;
      3'd4: return ~src;
      default: return dst;
    endcase
  endfunction

  // Applies at most limit dots of a command to the shadow copy
  task automatic model_cmd(input logic [3:0] cmd, input logic g4, input logic [3:0] lo,
                           input int limit);
    logic [9:0] x;
    logic [9:0] y;
    logic [9:0] cnt;
    logic [9:0] rows;
    logic [9:0] step;
    logic [16:0] a;
    logic [7:0] old;
    logic [7:0] res;
    logic [7:0] nw;
    logic single;
    logic done;
    int pixels;
    pixels = 0;
    if (cmd != CMD_HMMV && cmd != CMD_LMMV && cmd != CMD_PSET) return;
    single = cmd == CMD_PSET;
    step = (cmd == CMD_HMMV && g4) ? 10'd2 : 10'd1;
    if (cur_dix) step = 10'd0 - step;
    y = cur_dy;
    rows = cur_ny;
    done = 1'b0;
    while (!done) begin
      x = cur_dx;
      cnt = (cmd == CMD_HMMV && g4) ? cur_nx >> 1 : cur_nx;
      do begin
        a = vram_index(g4, x, y);
        old = shadow[a];
        res = logic_op(lo, g4 ? (cur_clr & 8'h0f) : cur_clr, pixel_at(g4, x, y));
        if (cmd == CMD_HMMV) nw = cur_clr;
        else if (!g4) nw = res;
        else if (x[0]) nw = {old[7:4], res[3:0]};
        else nw = {res[3:0], old[3:0]};
        if (pixels < limit) shadow[a] = nw;
        pixels++;
        x = x + step;
        cnt = cnt - 10'd1;
        // Bit 8 marks a step off either screen edge
      end while (cnt != 10'd0 && !x[8] && !single);
      if (single || rows == 10'd1 || (cur_diy && y == 10'd0)) begin
        done = 1'b1;
      end else begin
        y = y + (cur_diy ? 10'h3ff : 10'd1);
        rows = rows - 10'd1;
      end
    end
  endtask

  task automatic compare_vram();
    for (int a = 0; a < VRAM_BYTES; a++) begin
      if (mem[a] !== shadow[a]) begin
        check_value($sformatf("vram[%05h]", a), 32'(mem[a]), 32'(shadow[a]));
      end
    end
  endtask

  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  // Ack must follow on the edge that sees the toggle
  task automatic write_reg(input logic [3:0] num, input logic [7:0] data);
    reg_num = num;
    reg_data = data;
    reg_wr_req = ~reg_wr_req;
    tick();
    check_value("reg_wr_ack", 32'(reg_wr_ack), 32'(reg_wr_req));
  endtask

  task automatic load_regs(input logic [9:0] dx, dy, nx, ny, input logic [1:0] arg,
                           input logic [7:0] clr_v);
    write_reg(REG_DX_L, dx[7:0]);
    write_reg(REG_DX_H, {6'h0, dx[9:8]});
    write_reg(REG_DY_L, dy[7:0]);
    write_reg(REG_DY_H, {6'h0, dy[9:8]});
    write_reg(REG_NX_L, nx[7:0]);
    write_reg(REG_NX_H, {6'h0, nx[9:8]});
    write_reg(REG_NY_L, ny[7:0]);
    write_reg(REG_NY_H, {6'h0, ny[9:8]});
    // diy in bit 3 and dix in bit 2
    write_reg(REG_ARG, {4'h0, arg[1], arg[0], 2'b00});
    write_reg(REG_CLR, clr_v);
    // Dropped source register is acked and ignored
    write_reg(4'd0, 8'hff);
    cur_dx = dx;
    cur_dy = dy;
    cur_nx = nx;
    cur_ny = ny;
    cur_dix = arg[0];
    cur_diy = arg[1];
    cur_clr = clr_v;
  endtask

  task automatic run_cmd(input logic [7:0] cmd_byte, input logic g4);
    int n;
    n = 0;
    write_reg(REG_CMD, cmd_byte);
    while (!ce && n < 2) begin
      tick();
      n++;
    end
    check_value("ce", 32'(ce), 32'd1);
    check_value("current_command", 32'(current_command), 32'(cmd_byte[7:4]));
    while (ce) tick();
    model_cmd(cmd_byte[7:4], g4, cmd_byte[3:0], 1 << 30);
    compare_vram();
  endtask

  // Answers each toggled request after 0 to 3 cycles
  initial begin : vram_model
    logic [31:0] d;
    forever begin
      tick();
      if (vram_wr_req != vram_wr_ack) begin
        draw_bits(2, vram_lfsr, d);
        repeat (int'(d[1:0])) tick();
        mem[vram_addr] = vram_wr_data;
        wr_count++;
        vram_wr_ack = ~vram_wr_ack;
      end else if (vram_rd_req != vram_rd_ack) begin
        draw_bits(2, vram_lfsr, d);
        repeat (int'(d[1:0])) tick();
        vram_rd_data = mem[vram_addr];
        vram_rd_ack = ~vram_rd_ack;
      end
    end
  end

  initial begin : watchdog
    #(TIMEOUT_NS);
    $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
    $display("ERRORS FOUND");
    $fatal(1, "Watchdog expired");
  end

  initial begin : main
    logic [31:0] v;
    logic g4;
    logic [9:0] dx;
    logic [9:0] dy;
    logic [9:0] nx;
    logic [9:0] ny;
    logic [1:0] arg;
    logic [7:0] col;
    logic [3:0] cmd;
    logic [7:0] exp_point;
    int base;
    int done_writes;
    clk = 1'b0;
    reset = 1'b1;
    mode_graphic_4 = 1'b0;
    mode_graphic_7 = 1'b1;
    reg_wr_req = 1'b0;
    reg_num = 4'h0;
    reg_data = 8'h00;
    vram_rd_ack = 1'b0;
    vram_wr_ack = 1'b0;
    vram_rd_data = 8'h00;
    wr_count = 0;
    stim_lfsr = 32'hf75c;
    vram_lfsr = 32'hf75c;
    for (int a = 0; a < VRAM_BYTES; a++) begin
      mem[a] = fill_byte(17'(a));
      shadow[a] = mem[a];
    end
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;
    check_value("ce", 32'(ce), 32'd0);
    check_value("vram_rd_req", 32'(vram_rd_req), 32'd0);
    check_value("vram_wr_req", 32'(vram_wr_req), 32'd0);
    check_value("reg_wr_ack", 32'(reg_wr_ack), 32'd0);
    check_value("current_command", 32'(current_command), 32'(CMD_STOP));

    // HMMV, LMMV and PSET in turn
    // Op and transparent bit sweep with i
    for (int i = 0; i < N_RAND; i++) begin
      draw_bits(1, stim_lfsr, v);
      g4 = v[0];
      mode_graphic_4 = g4;
      mode_graphic_7 = ~g4;
      draw_bits(8, stim_lfsr, v);
      dx = 10'(v[7:0]);
      draw_bits(9, stim_lfsr, v);
      dy = 10'(v[8:0]);
      draw_bits(4, stim_lfsr, v);
      nx = 10'(v[3:0]) + 10'd2;
      draw_bits(3, stim_lfsr, v);
      ny = 10'(v[2:0]) + 10'd1;
      draw_bits(2, stim_lfsr, v);
      arg = v[1:0];
      draw_bits(8, stim_lfsr, v);
      col = v[7:0];
      if (i % 3 == 0) cmd = CMD_HMMV;
      else if (i % 3 == 1) cmd = CMD_LMMV;
      else cmd = CMD_PSET;
      load_regs(dx, dy, nx, ny, arg, col);
      // Previous command has ended
      check_value("current_command", 32'(current_command), 32'(CMD_STOP));
      run_cmd({cmd, 4'(i / 3)}, g4);
      if (cmd == CMD_PSET) begin
        // Read the plotted dot back
        exp_point = pixel_at(g4, dx, dy);
        run_cmd({CMD_POINT, 4'h0}, g4);
        check_value("clr", 32'(clr), 32'(exp_point));
      end
    end

    // Long graphic 7 fill cut short by STOP
    mode_graphic_4 = 1'b0;
    mode_graphic_7 = 1'b1;
    load_regs(10'd0, 10'd100, 10'h100, 10'd8, 2'b00, 8'h5a);
    base = wr_count;
    write_reg(REG_CMD, {CMD_HMMV, 4'h0});
    while (wr_count - base < 20) tick();
    write_reg(REG_CMD, {CMD_STOP, 4'h0});
    while (ce) tick();
    repeat (8) tick();
    done_writes = wr_count - base;
    repeat (50) tick();
    check_value("vram write count", 32'(wr_count - base), 32'(done_writes));
    check_value("vram_wr_req", 32'(vram_wr_req), 32'(vram_wr_ack));
    check_value("current_command", 32'(current_command), 32'(CMD_STOP));
    model_cmd(CMD_HMMV, 1'b0, 4'h0, done_writes);
    compare_vram();

    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

//--- vdp_cmd_pixel.sv
`timescale 1ns/1ps
`default_nettype none

module vdp_cmd_pixel import vdp_cmd_pkg::*; (
  input  logic   clk,
  input  logic   reset,
  vdp_cmd_regs_if.pixel regs,
  input  pixel_t clr,
  input  pixel_t vram_rd_data,
  input  logic   x_low,
  input  logic   capture,
  output pixel_t wr_data,
  output pixel_t point
);

  logic byte_cmd;
  pixel_t col_mask;
  pixel_t src;
  pixel_t result;
  pixel_t merged;

  assign byte_cmd = cmd_t'(regs.cmr[7:4]) == CMD_HMMV;
  assign col_mask = (byte_cmd || !regs.g4) ? 8'hff : 8'h0f;
  assign src      = clr & col_mask;

  // Even X sits in the high nibble
  always_comb begin
    if (regs.g4) begin
      point = x_low ? {4'h0, vram_rd_data[3:0]} : {4'h0, vram_rd_data[7:4]};
    end else begin
      point = vram_rd_data;
    end
  end

  always_comb begin
    // Transparent and zero colour leaves the destination alone
    if (!regs.cmr[3] || src != '0) begin
      case (logop_t'(regs.cmr[2:0]))
        LOP_IMP: result = src;
        LOP_AND: result = src & point;
        LOP_OR:  result = src | point;
        LOP_XOR: result = src ^ point;
        LOP_NOT: result = ~src;
        default: result = point;
      endcase
    end else begin
      result = point;
    end
  end

  // Put the new nibble back next to its neighbour
  always_comb begin
    if (regs.g4) begin
      merged = x_low ? {vram_rd_data[7:4], result[3:0]} : {result[3:0], vram_rd_data[3:0]};
    end else begin
      merged = result;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_data <= '0;
    end else if (capture) begin
      // HMMV writes the colour byte as is
      wr_data <= byte_cmd ? clr : merged;
    end
  end

endmodule

`default_nettype wire

//--- vdp_cmd_pkg.sv
`default_nettype none

package vdp_cmd_pkg;

  // Coordinate and count register width
  localparam int COORD_W = 10;
  // Byte address into 128 KiB of VRAM
  localparam int VRAM_AW = 17;

  // Command codes, upper nibble of the command register
  typedef enum logic [3:0] {
    CMD_STOP  = 4'b0000,
    CMD_POINT = 4'b0100,
    CMD_PSET  = 4'b0101,
    CMD_LMMV  = 4'b1000,
    CMD_HMMV  = 4'b1100
  } cmd_t;

  // Logical operations, low three bits of the command register
  typedef enum logic [2:0] {
    LOP_IMP = 3'd0,
    LOP_AND = 3'd1,
    LOP_OR  = 3'd2,
    LOP_XOR = 3'd3,
    LOP_NOT = 3'd4
  } logop_t;

  typedef logic [COORD_W-1:0] coord_t;
  typedef logic [VRAM_AW-1:0] vram_addr_t;
  typedef logic [7:0]         pixel_t;

  // Direction bits of the argument register
  typedef struct packed {
    logic diy;
    logic dix;
  } arg_t;

  // Register numbers, offset from register 32
  localparam logic [3:0] REG_DX_L = 4'd4;
  localparam logic [3:0] REG_DX_H = 4'd5;
  localparam logic [3:0] REG_DY_L = 4'd6;
  localparam logic [3:0] REG_DY_H = 4'd7;
  localparam logic [3:0] REG_NX_L = 4'd8;
  localparam logic [3:0] REG_NX_H = 4'd9;
  localparam logic [3:0] REG_NY_L = 4'd10;
  localparam logic [3:0] REG_NY_H = 4'd11;
  localparam logic [3:0] REG_CLR  = 4'd12;
  localparam logic [3:0] REG_ARG  = 4'd13;
  localparam logic [3:0] REG_CMD  = 4'd14;

endpackage

`default_nettype wire

//--- vdp_cmd_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module vdp_cmd_regfile import vdp_cmd_pkg::*; (
  input  logic   clk,
  input  logic   reset,
  input  logic   mode_graphic_4,
  input  logic   mode_graphic_7,
  input  logic   reg_wr_req,
  input  logic   [3:0] reg_num,
  input  pixel_t reg_data,
  input  logic   ce,
  input  logic   clr_load,
  input  pixel_t clr_load_data,
  input  logic   clr_remask,
  output logic   reg_wr_ack,
  vdp_cmd_regs_if.source regs,
  output pixel_t clr,
  output logic   start,
  output logic   write_pending
);

  coord_t dx_reg;
  coord_t dy_reg;
  coord_t nx_reg;
  coord_t ny_reg;
  arg_t arg_reg;
  logic [7:0] cmr_reg;
  logic ce_q;
  pixel_t col_mask;

  // Request differs from ack while a write waits
  assign write_pending = reg_wr_req != reg_wr_ack;

  // Byte commands keep all eight bits
  // Dot commands in graphic 4 keep one nibble
  assign col_mask = (cmr_reg[7:6] == 2'b11 || !mode_graphic_4) ? 8'hff : 8'h0f;

  assign regs.dx  = dx_reg;
  assign regs.dy  = dy_reg;
  assign regs.nx  = nx_reg;
  assign regs.ny  = ny_reg;
  assign regs.arg = arg_reg;
  assign regs.cmr = cmr_reg;
  assign regs.g4  = mode_graphic_4;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      dx_reg     <= '0;
      dy_reg     <= '0;
      nx_reg     <= '0;
      ny_reg     <= '0;
      arg_reg    <= '0;
      cmr_reg    <= {CMD_STOP, 4'h0};
      clr        <= '0;
      reg_wr_ack <= 1'b0;
      start      <= 1'b0;
      ce_q       <= 1'b0;
    end else begin
      start <= 1'b0;
      ce_q  <= ce;
      // Command finished so back to STOP
      if (ce_q && !ce) begin
        cmr_reg <= {CMD_STOP, 4'h0};
      end
      // CPU write wins over anything the engine asks for
      if (write_pending) begin
        reg_wr_ack <= ~reg_wr_ack;
        case (reg_num)
          REG_DX_L: dx_reg[7:0] <= reg_data;
          REG_DX_H: dx_reg[9:8] <= reg_data[1:0];
          REG_DY_L: dy_reg[7:0] <= reg_data;
          REG_DY_H: dy_reg[9:8] <= reg_data[1:0];
          REG_NX_L: nx_reg[7:0] <= reg_data;
          REG_NX_H: nx_reg[9:8] <= reg_data[1:0];
          REG_NY_L: ny_reg[7:0] <= reg_data;
          REG_NY_H: ny_reg[9:8] <= reg_data[1:0];
          REG_CLR: clr <= ce ? (reg_data & col_mask) : reg_data;
          REG_ARG: begin
            arg_reg.dix <= reg_data[2];
            arg_reg.diy <= reg_data[3];
          end
          REG_CMD: begin
            // Also aborts a running command
            cmr_reg <= reg_data;
            start   <= mode_graphic_4 | mode_graphic_7;
          end
          // Source, search and mode registers are gone
          default: ;
        endcase
      end else if (clr_load) begin
        // POINT result
        clr <= clr_load_data;
      end else if (clr_remask) begin
        clr <= clr & col_mask;
      end
    end
  end

endmodule

`default_nettype wire

//--- vdp_cmd_regs_if.sv
`timescale 1ns/1ps
`default_nettype none

interface vdp_cmd_regs_if import vdp_cmd_pkg::*; ();

  // Destination corner and rectangle size
  coord_t dx;
  coord_t dy;
  coord_t nx;
  coord_t ny;
  // Direction bits
  arg_t arg;
  // Command nibble, transparent bit, logical op
  logic [7:0] cmr;
  // High in graphic 4, two pixels per byte
  logic g4;

  modport source (output dx, dy, nx, ny, arg, cmr, g4);
  modport walker (input dx, dy, nx, ny, arg, cmr, g4);
  modport pixel (input cmr, g4);
  modport seq (input cmr);

endinterface

`default_nettype wire

//--- vdp_cmd_seq.sv
`timescale 1ns/1ps
`default_nettype none

module vdp_cmd_seq import vdp_cmd_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  vdp_cmd_regs_if.seq regs,
  input  logic       start,
  input  logic       write_pending,
  input  logic       row_end,
  input  logic       rect_end,
  input  vram_addr_t addr,
  input  pixel_t     wr_data,
  input  logic       vram_rd_ack,
  input  logic       vram_wr_ack,
  output logic       ce,
  output logic       vram_rd_req,
  output logic       vram_wr_req,
  output vram_addr_t vram_addr,
  output pixel_t     vram_wr_data,
  output logic       step_x,
  output logic       next_row,
  output logic       capture,
  output logic       clr_load,
  output logic       clr_remask
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_CHK,
    S_RD,
    S_RD_WAIT,
    S_WR,
    S_WR_WAIT,
    S_END
  } state_t;

  state_t state;
  state_t state_n;
  cmd_t cmd;
  logic first;
  logic run;
  logic rd_done;
  logic wr_done;

  assign cmd     = cmd_t'(regs.cmr[7:4]);
  // Nothing moves while the CPU writes or a command is being loaded
  assign run     = !write_pending && !start;
  assign rd_done = vram_rd_req == vram_rd_ack;
  assign wr_done = vram_wr_req == vram_wr_ack;

  always_comb begin
    state_n    = state;
    step_x     = 1'b0;
    next_row   = 1'b0;
    capture    = 1'b0;
    clr_load   = 1'b0;
    clr_remask = 1'b0;
    if (run) begin
      case (state)
        S_CHK: begin
          // The first pass only dispatches, later passes check loop end
          if (!first && row_end && rect_end) begin
            state_n = S_END;
          end else begin
            next_row   = !first && row_end;
            clr_remask = 1'b1;
            case (cmd)
              CMD_HMMV: begin
                capture = 1'b1;
                state_n = S_WR;
              end
              CMD_LMMV, CMD_PSET, CMD_POINT: state_n = S_RD;
              // STOP and unknown codes
              default: state_n = S_END;
            endcase
          end
        end
        // Issue states wait for any older access to finish
        S_RD: if (rd_done) state_n = S_RD_WAIT;
        S_RD_WAIT: begin
          if (rd_done) begin
            clr_load = cmd == CMD_POINT;
            capture  = cmd != CMD_POINT;
            state_n  = (cmd == CMD_POINT) ? S_END : S_WR;
          end
        end
        S_WR: if (wr_done) state_n = S_WR_WAIT;
        S_WR_WAIT: begin
          if (wr_done) begin
            step_x  = cmd != CMD_PSET;
            state_n = (cmd == CMD_PSET) ? S_END : S_CHK;
          end
        end
        S_END: state_n = S_IDLE;
        default: state_n = S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state       <= S_IDLE;
      ce          <= 1'b0;
      first       <= 1'b0;
      vram_rd_req <= 1'b0;
      vram_wr_req <= 1'b0;
    end else if (!write_pending) begin
      if (start) begin
        // New command, abandons whatever ran before
        state <= S_CHK;
        ce    <= 1'b1;
        first <= 1'b1;
      end else begin
        state <= state_n;
        if (state == S_CHK) first <= 1'b0;
        if (state == S_RD && rd_done) vram_rd_req <= ~vram_rd_ack;
        if (state == S_WR && wr_done) vram_wr_req <= ~vram_wr_ack;
        if (state == S_END) ce <= 1'b0;
      end
    end
  end

  // Address and data stay put until the access is acknowledged
  always_ff @(posedge clk) begin
    if (run && state == S_RD && rd_done) begin
      vram_addr <= addr;
    end
    if (run && state == S_WR && wr_done) begin
      vram_addr    <= addr;
      vram_wr_data <= wr_data;
    end
  end

endmodule

`default_nettype wire

//--- vdp_cmd_top.sv
`timescale 1ns/1ps
`default_nettype none

module vdp_cmd_top import vdp_cmd_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       mode_graphic_4,
  input  logic       mode_graphic_7,
  input  logic       reg_wr_req,
  input  logic [3:0] reg_num,
  input  pixel_t     reg_data,
  input  logic       vram_rd_ack,
  input  logic       vram_wr_ack,
  input  pixel_t     vram_rd_data,
  output logic       reg_wr_ack,
  output logic       vram_rd_req,
  output logic       vram_wr_req,
  output vram_addr_t vram_addr,
  output pixel_t     vram_wr_data,
  output pixel_t     clr,
  output logic       ce,
  output logic [3:0] current_command
);

  // Strobes between the units
  logic start;
  logic write_pending;
  logic step_x;
  logic next_row;
  logic capture;
  logic clr_load;
  logic clr_remask;
  // Walker results
  vram_addr_t addr;
  logic x_low;
  logic row_end;
  logic rect_end;
  // Pixel unit results
  pixel_t wr_data;
  pixel_t point;

  vdp_cmd_regs_if regs_if ();

  assign current_command = regs_if.cmr[7:4];

  vdp_cmd_regfile regfile_i (
    .clk            (clk),
    .reset          (reset),
    .mode_graphic_4 (mode_graphic_4),
    .mode_graphic_7 (mode_graphic_7),
    .reg_wr_req     (reg_wr_req),
    .reg_num        (reg_num),
    .reg_data       (reg_data),
    .ce             (ce),
    .clr_load       (clr_load),
    .clr_load_data  (point),
    .clr_remask     (clr_remask),
    .reg_wr_ack     (reg_wr_ack),
    .regs           (regs_if.source),
    .clr            (clr),
    .start          (start),
    .write_pending  (write_pending)
  );

  vdp_cmd_walker walker_i (
    .clk      (clk),
    .reset    (reset),
    .regs     (regs_if.walker),
    .start    (start),
    .step_x   (step_x),
    .next_row (next_row),
    .addr     (addr),
    .x_low    (x_low),
    .row_end  (row_end),
    .rect_end (rect_end)
  );

  vdp_cmd_pixel pixel_i (
    .clk          (clk),
    .reset        (reset),
    .regs         (regs_if.pixel),
    .clr          (clr),
    .vram_rd_data (vram_rd_data),
    .x_low        (x_low),
    .capture      (capture),
    .wr_data      (wr_data),
    .point        (point)
  );

  vdp_cmd_seq seq_i (
    .clk           (clk),
    .reset         (reset),
    .regs          (regs_if.seq),
    .start         (start),
    .write_pending (write_pending),
    .row_end       (row_end),
    .rect_end      (rect_end),
    .addr          (addr),
    .wr_data       (wr_data),
    .vram_rd_ack   (vram_rd_ack),
    .vram_wr_ack   (vram_wr_ack),
    .ce            (ce),
    .vram_rd_req   (vram_rd_req),
    .vram_wr_req   (vram_wr_req),
    .vram_addr     (vram_addr),
    .vram_wr_data  (vram_wr_data),
    .step_x        (step_x),
    .next_row      (next_row),
    .capture       (capture),
    .clr_load      (clr_load),
    .clr_remask    (clr_remask)
  );

endmodule

`default_nettype wire

//--- vdp_cmd_walker.sv
`timescale 1ns/1ps
`default_nettype none

module vdp_cmd_walker import vdp_cmd_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  vdp_cmd_regs_if.walker regs,
  input  logic       start,
  input  logic       step_x,
  input  logic       next_row,
  output vram_addr_t addr,
  output logic       x_low,
  output logic       row_end,
  output logic       rect_end
);

  // Current destination position
  coord_t x_pos;
  coord_t y_pos;
  // Dots left in the row, rows left in the rectangle
  coord_t nx_cnt;
  coord_t ny_cnt;

  logic hmmv_g4;
  coord_t x_step;
  coord_t x_delta;
  coord_t y_delta;
  coord_t nx_load;

  // HMMV in graphic 4 moves a byte, so two pixels at a time
  assign hmmv_g4 = (cmd_t'(regs.cmr[7:4]) == CMD_HMMV) && regs.g4;
  assign x_step  = hmmv_g4 ? coord_t'(2) : coord_t'(1);
  assign x_delta = regs.arg.dix ? coord_t'(0) - x_step : x_step;
  assign y_delta = regs.arg.diy ? '1 : coord_t'(1);
  assign nx_load = hmmv_g4 ? {1'b0, regs.nx[COORD_W-1:1]} : regs.nx;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      x_pos  <= '0;
      y_pos  <= '0;
      nx_cnt <= '0;
      ny_cnt <= '0;
    end else if (start) begin
      x_pos  <= regs.dx;
      y_pos  <= regs.dy;
      nx_cnt <= nx_load;
      ny_cnt <= regs.ny;
    end else if (step_x) begin
      x_pos  <= x_pos + x_delta;
      nx_cnt <= nx_cnt - coord_t'(1);
    end else if (next_row) begin
      // Back to the left edge, one line on
      x_pos  <= regs.dx;
      y_pos  <= y_pos + y_delta;
      nx_cnt <= nx_load;
      ny_cnt <= ny_cnt - coord_t'(1);
    end
  end

  // Bit 8 set means X went past 255, or below 0 when walking left
  assign row_end  = (nx_cnt == '0) || x_pos[8];
  assign rect_end = (ny_cnt == coord_t'(1)) || (regs.arg.diy && (y_pos == '0));

  assign x_low = x_pos[0];

  always_comb begin
    if (regs.g4) begin
      // 128 bytes per line
      addr = {y_pos, x_pos[7:1]};
    end else begin
      // 256 bytes per line
      addr = {y_pos[8:0], x_pos[7:0]};
    end
  end

endmodule

`default_nettype wire

//--- verilog.f
vdp_cmd_pkg.sv
vdp_cmd_regs_if.sv
vdp_cmd_regfile.sv
vdp_cmd_walker.sv
vdp_cmd_pixel.sv
vdp_cmd_seq.sv
vdp_cmd_top.sv
tb_vdp_cmd.sv
